//--- tb/e1000_intr_trace.txt
# wr addr data | rd addr data pslverr | pins lsc phyint sdp6 sdp7 | phy fd lu speed | prst level
# rreq | wait cycles | wint level timeout | gap min_cycles | end name  (addr and data in hex)
phy 1 1 2
prst 0
wr 0000 80000000
prst 1
rd 0008 00000083 0
rd 0100 00000000 1
wr 0000 04000000
rreq
prst 0
end registers
pins 1 0 0 0
wait 4
rd 00C0 00000004 0
pins 1 1 1 1
wait 4
rd 00C0 00007000 0
rd 00C0 00000000 0
end cause_capture
wr 00C8 00004000
wint 0 3
wr 00D0 00004000
wint 1 4
rd 00D0 00004000 0
wr 00D8 00004000
wint 0 4
rd 00C0 00004000 0
end masking
wr 00C8 00002001
rd 00C0 00002000 0
wr 00C8 00002000
wr 00C0 00002000
rd 00C0 00000000 0
end software_causes
wr 00C4 0000000A
wr 00D0 00000004
pins 0 1 1 1
wait 3
pins 1 1 1 1
wint 1 10
rd 00C0 00000004 0
pins 0 1 1 1
wait 3
pins 1 1 1 1
gap 40
wr 00C4 00000000
rd 00C0 00000004 0
pins 0 1 1 1
wait 3
pins 1 1 1 1
wint 1 5
end throttle

//--- build.f
verilog/e1000_reg_pkg.sv
verilog/e1000_intr_pkg.sv
verilog/e1000_csr.sv
verilog/intr_cause_cell.sv
verilog/intr_throttle.sv
verilog/e1000_intr_top.sv
tb/e1000_intr_checker.sv
tb/tb_e1000_intr.sv

//--- Bender.yml
package:
  name: e1000_intr

sources:
  - verilog/e1000_reg_pkg.sv
  - verilog/e1000_intr_pkg.sv
  - verilog/e1000_csr.sv
  - verilog/intr_cause_cell.sv
  - verilog/intr_throttle.sv
  - verilog/e1000_intr_top.sv
  - target: test
    files:
      - tb/e1000_intr_checker.sv
      - tb/tb_e1000_intr.sv

//--- tb/tb_e1000_intr.sv
`default_nettype none
`timescale 1ns/100ps

module tb_e1000_intr;

	localparam int DRV_DLY = 2;         // Input skew after the rising edge
	localparam int APB_TIMEOUT = 16;
	localparam int PULSE_TIMEOUT = 8;
	localparam int GAP_TIMEOUT = 200;

	logic                       aclk;
	logic                       rst_i;
	e1000_reg_pkg::apb_req_t    apb_req;
	e1000_reg_pkg::apb_rsp_t    apb_rsp;
	e1000_reg_pkg::phy_status_t phy_status;
	logic [3:0]                 pins;   // By cause index
	logic                       intr_request;
	logic                       reset_request;
	logic                       phy_reset;

	int   cyc;
	int   last_fall;
	logic intr_seen;
	int   test_errors;
	int   total_errors;
	int   checks;
	int   tests;
	int   tests_failed;

	e1000_intr_top #(
		.ITR_TICK_CYCLES (4)
	) i_dut (
		.aclk            (aclk),
		.rst_i           (rst_i),
		.apb_req_i       (apb_req),
		.apb_rsp_o       (apb_rsp),
		.phy_status_i    (phy_status),
		.phy_int_i       (pins[e1000_intr_pkg::CAUSE_PHYINT]),
		.phy_lsc_i       (pins[e1000_intr_pkg::CAUSE_LSC]),
		.sdp6_i          (pins[e1000_intr_pkg::CAUSE_SDP6]),
		.sdp7_i          (pins[e1000_intr_pkg::CAUSE_SDP7]),
		.intr_request_o  (intr_request),
		.reset_request_o (reset_request),
		.phy_reset_o     (phy_reset)
	);

	always #20 aclk = ~aclk;

	always @(posedge aclk) begin
		cyc <= cyc + 1;
	end

	// Cycle of the last falling request, for the ITR gap
	always @(negedge aclk) begin
		if (intr_seen && !intr_request) begin
			last_fall = cyc;
		end
		intr_seen = intr_request;
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0d ns: %s, got %h expected %h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0d ns: %s", $time, what);
		test_errors++;
	endtask

	task automatic apb_access(input logic write, input logic [15:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr);
		int n;
		@(posedge aclk);
		#DRV_DLY;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge aclk);
		#DRV_DLY;
		apb_req.penable = 1'b1;
		n = 0;
		@(negedge aclk);
		while (!apb_rsp.pready && n < APB_TIMEOUT) begin
			@(negedge aclk);
			n++;
		end
		if (!apb_rsp.pready) begin
			report_timeout("APB slave never raised pready");
		end
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(posedge aclk);    // Access ends here
		#DRV_DLY;
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic wait_intr(input logic level, input int timeout);
		int n;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (intr_request !== level && n < timeout);
		checks++;
		if (intr_request !== level) begin
			report_timeout($sformatf("interrupt request not at %0d within %0d cycles", level, timeout));
		end else begin
			// Must then hold for the rest of the window
			while (n < timeout) begin
				@(negedge aclk);
				n++;
				check_value(intr_request, level, "interrupt request left its expected level");
			end
		end
	endtask

	task automatic check_gap(input int min_cycles);
		int n;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (intr_request !== 1'b1 && n < GAP_TIMEOUT);
		if (intr_request !== 1'b1) begin
			report_timeout("interrupt request did not come back after the quiet interval");
		end else begin
			check_value(cyc - last_fall >= min_cycles, 1'b1,
				$sformatf("request gap of %0d cycles, minimum %0d", cyc - last_fall, min_cycles));
		end
	endtask

	task automatic check_reset_pulse();
		int n;
		n = 0;
		@(negedge aclk);
		while (!reset_request && n < PULSE_TIMEOUT) begin
			@(negedge aclk);
			n++;
		end
		if (!reset_request) begin
			report_timeout("reset request never rose after the CTRL.RST write");
		end else begin
			@(negedge aclk);
			check_value(reset_request, 1'b0, "reset request longer than one cycle");
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (test_errors == 0) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		int               fd;
		int               n;
		logic [8*16-1:0]  cmd;
		logic [8*32-1:0]  name;
		logic [8*128-1:0] line;
		logic [31:0]      addr;
		logic [31:0]      data;
		logic [31:0]      rdata;
		logic             slverr;
		int               v0;
		int               v1;
		int               v2;
		int               v3;
		aclk = 1'b0;
		rst_i = 1'b1;
		apb_req = '0;
		phy_status = '0;
		pins = '0;
		cyc = 0;
		last_fall = 0;
		intr_seen = 1'b0;
		{test_errors, total_errors, checks, tests, tests_failed} = '0;
		repeat (10) @(posedge aclk);
		#DRV_DLY;
		rst_i = 1'b0;
		fd = $fopen("tb/e1000_intr_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file");
			total_errors++;
		end else begin
			while ($fscanf(fd, "%s", cmd) == 1) begin
				case (cmd)
					"#": n = $fgets(line, fd);
					"wr": begin
						n = $fscanf(fd, "%h %h", addr, data);
						apb_access(1'b1, addr[15:0], data, rdata, slverr);
					end
					"rd": begin
						n = $fscanf(fd, "%h %h %d", addr, data, v0);
						apb_access(1'b0, addr[15:0], '0, rdata, slverr);
						check_value(rdata, data, $sformatf("read data at %h", addr[15:0]));
						check_value(slverr, v0, $sformatf("pslverr at %h", addr[15:0]));
					end
					"pins": begin
						n = $fscanf(fd, "%d %d %d %d", v0, v1, v2, v3);
						@(posedge aclk);
						#DRV_DLY;
						pins = {v3[0], v2[0], v1[0], v0[0]};
					end
					"phy": begin
						n = $fscanf(fd, "%d %d %d", v0, v1, v2);
						@(posedge aclk);
						#DRV_DLY;
						phy_status = '{duplex: v0[0], link_up: v1[0], speed: v2[1:0]};
					end
					"prst": begin
						n = $fscanf(fd, "%d", v0);
						@(negedge aclk);
						check_value(phy_reset, v0, "phy_reset_o level");
					end
					"rreq": check_reset_pulse();
					"wait": begin
						n = $fscanf(fd, "%d", v0);
						repeat (v0) @(posedge aclk);
					end
					"wint": begin
						n = $fscanf(fd, "%d %d", v0, v1);
						wait_intr(v0[0], v1);
					end
					"gap": begin
						n = $fscanf(fd, "%d", v0);
						check_gap(v0);
					end
					"end": begin
						n = $fscanf(fd, "%s", name);
						finish_test(string'(name));
					end
					default: begin
						$display("Unknown trace command %s", string'(cmd));
						total_errors++;
						n = $fgets(line, fd);
					end
				endcase
			end
			$fclose(fd);
		end
		total_errors += test_errors;
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, tests_failed, checks, total_errors);
		if (total_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/e1000_intr_checker.sv
`default_nettype none
`timescale 1ns/100ps

module e1000_intr_checker (
	input wire                          aclk,
	input wire                          rst_i,
	input wire e1000_reg_pkg::apb_req_t apb_req_i,
	input wire e1000_reg_pkg::apb_rsp_t apb_rsp_i,
	input wire                          intr_request_i,
	input wire                          reset_request_i,
	input wire                          phy_reset_i
);

	// No wait states
	a_pready: assert property (@(posedge aclk)
		apb_req_i.psel && apb_req_i.penable |-> apb_rsp_i.pready)
		else $error("pready low in an APB access phase");

	a_reset_pulse: assert property (@(posedge aclk) disable iff (rst_i)
		reset_request_i |=> !reset_request_i)
		else $error("reset_request_o high for two cycles running");

	a_phy_reset: assert property (@(posedge aclk) rst_i |-> phy_reset_i)
		else $error("phy_reset_o low while rst_i is high");

	// Synchronous reset, visible one edge later
	a_intr_reset: assert property (@(posedge aclk) rst_i |=> !intr_request_i)
		else $error("intr_request_o high during reset");

endmodule

bind e1000_intr_top e1000_intr_checker i_checker (
	.aclk            (aclk),
	.rst_i           (rst_i),
	.apb_req_i       (apb_req_i),
	.apb_rsp_i       (apb_rsp_o),
	.intr_request_i  (intr_request_o),
	.reset_request_i (reset_request_o),
	.phy_reset_i     (phy_reset_o)
);

`default_nettype wire

//--- verilog/e1000_intr_top.sv
`default_nettype none
`timescale 1ns/100ps

module e1000_intr_top #(
	parameter int ITR_TICK_CYCLES = 8
) (
	input  wire                              aclk,
	input  wire                              rst_i,
	input  wire e1000_reg_pkg::apb_req_t     apb_req_i,
	output e1000_reg_pkg::apb_rsp_t          apb_rsp_o,
	input  wire e1000_reg_pkg::phy_status_t  phy_status_i,
	input  wire                              phy_int_i,
	input  wire                              phy_lsc_i,
	input  wire                              sdp6_i,
	input  wire                              sdp7_i,
	output wire                              intr_request_o,
	output wire                              reset_request_o,
	output wire                              phy_reset_o
);

	wire e1000_intr_pkg::cause_vec_t cause_pins;
	wire e1000_intr_pkg::cause_vec_t pending;
	wire e1000_intr_pkg::cause_vec_t mask;
	wire [e1000_intr_pkg::ITR_W-1:0] itr;
	wire e1000_intr_pkg::cause_ctl_t [e1000_intr_pkg::NUM_CAUSES-1:0] cause_ctl;

	// Pins by cause index
	assign cause_pins[e1000_intr_pkg::CAUSE_LSC] = phy_lsc_i;
	assign cause_pins[e1000_intr_pkg::CAUSE_PHYINT] = phy_int_i;
	assign cause_pins[e1000_intr_pkg::CAUSE_SDP6] = sdp6_i;
	assign cause_pins[e1000_intr_pkg::CAUSE_SDP7] = sdp7_i;

	e1000_csr i_csr (
		.aclk            (aclk),
		.rst_i           (rst_i),
		.apb_req_i       (apb_req_i),
		.apb_rsp_o       (apb_rsp_o),
		.phy_status_i    (phy_status_i),
		.pending_i       (pending),
		.cause_ctl_o     (cause_ctl),
		.mask_o          (mask),
		.itr_o           (itr),
		.reset_request_o (reset_request_o),
		.phy_reset_o     (phy_reset_o)
	);

	for (genvar i = 0; i < e1000_intr_pkg::NUM_CAUSES; i++) begin : g_cause
		intr_cause_cell i_cell (
			.aclk      (aclk),
			.rst_i     (rst_i),
			.cause_i   (cause_pins[i]),
			.ctl_i     (cause_ctl[i]),
			.pending_o (pending[i])
		);
	end

	intr_throttle #(
		.ITR_TICK_CYCLES (ITR_TICK_CYCLES)
	) i_throttle (
		.aclk           (aclk),
		.rst_i          (rst_i),
		.pending_i      (pending),
		.mask_i         (mask),
		.itr_i          (itr),
		.intr_request_o (intr_request_o)
	);

endmodule

`default_nettype wire

//--- verilog/intr_throttle.sv
`default_nettype none
`timescale 1ns/100ps

module intr_throttle #(
	parameter int ITR_TICK_CYCLES = 8   // Clock cycles per ITR unit
) (
	input  wire                               aclk,
	input  wire                               rst_i,
	input  wire e1000_intr_pkg::cause_vec_t   pending_i,
	input  wire e1000_intr_pkg::cause_vec_t   mask_i,
	input  wire [e1000_intr_pkg::ITR_W-1:0]   itr_i,
	output logic                              intr_request_o
);

	localparam int CNT_W = e1000_intr_pkg::ITR_W + $clog2(ITR_TICK_CYCLES + 1);

	logic             any_masked;
	logic [CNT_W-1:0] gap_load;
	logic [CNT_W-1:0] gap_cnt_q;
	logic             intr_q;

	assign any_masked = |(pending_i & mask_i);

	// Interval in clock cycles
	assign gap_load = CNT_W'(itr_i) * CNT_W'(ITR_TICK_CYCLES);

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			intr_q <= 1'b0;
			gap_cnt_q <= '0;
		end else if (intr_q) begin
			if (!any_masked) begin
				intr_q <= 1'b0;
				gap_cnt_q <= gap_load;   // Start of quiet interval
			end
		end else if (gap_cnt_q != '0) begin
			gap_cnt_q <= gap_cnt_q - 1'b1;
		end else if (any_masked) begin
			intr_q <= 1'b1;
		end
	end

	assign intr_request_o = intr_q;

endmodule

`default_nettype wire

//--- verilog/intr_cause_cell.sv
`default_nettype none
`timescale 1ns/100ps

module intr_cause_cell (
	input  wire                             aclk,
	input  wire                             rst_i,
	input  wire                             cause_i,   // Asynchronous pin
	input  wire e1000_intr_pkg::cause_ctl_t ctl_i,
	output logic                            pending_o
);

	logic [1:0] sync_q;
	logic       sync_d_q;
	logic       rise;

	// Edge on the synchronized level
	assign rise = sync_q[1] && !sync_d_q;

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			sync_q <= '0;
			sync_d_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], cause_i};
			sync_d_q <= sync_q[1];
		end
	end

	// Sticky pending, set beats clear
	always_ff @(posedge aclk) begin
		if (rst_i) begin
			pending_o <= 1'b0;
		end else if (rise || ctl_i.set) begin
			pending_o <= 1'b1;
		end else if (ctl_i.clr) begin
			pending_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/e1000_csr.sv
`default_nettype none
`timescale 1ns/100ps

module e1000_csr (
	input  wire                                                    aclk,
	input  wire                                                    rst_i,
	input  wire e1000_reg_pkg::apb_req_t                           apb_req_i,
	output e1000_reg_pkg::apb_rsp_t                                apb_rsp_o,
	input  wire e1000_reg_pkg::phy_status_t                        phy_status_i,
	input  wire e1000_intr_pkg::cause_vec_t                        pending_i,
	output e1000_intr_pkg::cause_ctl_t [e1000_intr_pkg::NUM_CAUSES-1:0] cause_ctl_o,
	output e1000_intr_pkg::cause_vec_t                             mask_o,
	output logic [e1000_intr_pkg::ITR_W-1:0]                       itr_o,
	output logic                                                   reset_request_o,
	output logic                                                   phy_reset_o
);

	localparam int REG_W = e1000_reg_pkg::REG_W;
	localparam int ITR_W = e1000_intr_pkg::ITR_W;
	localparam int NUM_CAUSES = e1000_intr_pkg::NUM_CAUSES;

	logic                       access;
	logic                       wr_en;
	logic                       rd_en;
	logic                       addr_hit;
	logic [REG_W-1:0]           rdata;
	logic [REG_W-1:0]           ctrl_word;
	logic [REG_W-1:0]           status_word;
	e1000_intr_pkg::cause_vec_t wr_causes;
	logic                       ctrl_rst_q;
	logic                       ctrl_phy_rst_q;
	e1000_intr_pkg::cause_vec_t mask_q;
	logic [ITR_W-1:0]           itr_q;

	// Cause vector to ICR bit layout
	function automatic logic [REG_W-1:0] to_icr(input e1000_intr_pkg::cause_vec_t v);
		logic [REG_W-1:0] w;
		w = '0;
		for (int i = 0; i < NUM_CAUSES; i++) begin
			w[e1000_intr_pkg::CAUSE_ICR_BIT[i]] = v[i];
		end
		return w;
	endfunction

	function automatic e1000_intr_pkg::cause_vec_t from_icr(input logic [REG_W-1:0] w);
		e1000_intr_pkg::cause_vec_t v;
		for (int i = 0; i < NUM_CAUSES; i++) begin
			v[i] = w[e1000_intr_pkg::CAUSE_ICR_BIT[i]];
		end
		return v;
	endfunction

	assign access = apb_req_i.psel && apb_req_i.penable;
	assign wr_en = access && apb_req_i.pwrite && addr_hit;
	assign rd_en = access && !apb_req_i.pwrite;
	assign wr_causes = from_icr(apb_req_i.pwdata);

	always_comb begin
		ctrl_word = '0;
		ctrl_word[e1000_reg_pkg::CTRL_RST_BIT] = ctrl_rst_q;
		ctrl_word[e1000_reg_pkg::CTRL_PHY_RST_BIT] = ctrl_phy_rst_q;
		status_word = '0;
		status_word[e1000_reg_pkg::STATUS_FD_BIT] = phy_status_i.duplex;
		status_word[e1000_reg_pkg::STATUS_LU_BIT] = phy_status_i.link_up;
		status_word[e1000_reg_pkg::STATUS_SPEED_LSB +: 2] = phy_status_i.speed;
	end

	// Read mux and address decode
	always_comb begin
		rdata = '0;
		addr_hit = 1'b1;
		case (apb_req_i.paddr)
			e1000_reg_pkg::CTRL_OFS:   rdata = ctrl_word;
			e1000_reg_pkg::STATUS_OFS: rdata = status_word;
			e1000_reg_pkg::ICR_OFS:    rdata = to_icr(pending_i);
			e1000_reg_pkg::ITR_OFS:    rdata = REG_W'(itr_q);
			e1000_reg_pkg::IMS_OFS:    rdata = to_icr(mask_q);
			e1000_reg_pkg::ICS_OFS,
			e1000_reg_pkg::IMC_OFS:    rdata = '0;   // Write only
			default:                   addr_hit = 1'b0;
		endcase
	end

	assign apb_rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: access && !addr_hit};

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			ctrl_rst_q <= 1'b0;
			ctrl_phy_rst_q <= 1'b0;
			mask_q <= '0;
			itr_q <= '0;
		end else begin
			// Only ever high for the cycle after the write
			ctrl_rst_q <= wr_en && apb_req_i.paddr == e1000_reg_pkg::CTRL_OFS &&
				apb_req_i.pwdata[e1000_reg_pkg::CTRL_RST_BIT];
			if (wr_en && apb_req_i.paddr == e1000_reg_pkg::CTRL_OFS) begin
				ctrl_phy_rst_q <= apb_req_i.pwdata[e1000_reg_pkg::CTRL_PHY_RST_BIT];
			end
			if (wr_en && apb_req_i.paddr == e1000_reg_pkg::IMS_OFS) begin
				mask_q <= mask_q | wr_causes;
			end else if (wr_en && apb_req_i.paddr == e1000_reg_pkg::IMC_OFS) begin
				mask_q <= mask_q & ~wr_causes;
			end
			if (wr_en && apb_req_i.paddr == e1000_reg_pkg::ITR_OFS) begin
				itr_q <= apb_req_i.pwdata[ITR_W-1:0];
			end
		end
	end

	// Per cell set/clear strobes
	always_comb begin
		for (int i = 0; i < NUM_CAUSES; i++) begin
			cause_ctl_o[i].set = wr_en && apb_req_i.paddr == e1000_reg_pkg::ICS_OFS &&
				wr_causes[i];
			// Read to clear, or write 1 to clear
			cause_ctl_o[i].clr = apb_req_i.paddr == e1000_reg_pkg::ICR_OFS &&
				(rd_en || (wr_en && wr_causes[i]));
		end
	end

	assign mask_o = mask_q;
	assign itr_o = itr_q;
	assign reset_request_o = ctrl_rst_q;
	assign phy_reset_o = ctrl_phy_rst_q || rst_i;

endmodule

`default_nettype wire

//--- verilog/e1000_intr_pkg.sv
`default_nettype none

package e1000_intr_pkg;

	localparam int NUM_CAUSES = 4;

	// Cause cell indices
	localparam int CAUSE_LSC = 0;
	localparam int CAUSE_PHYINT = 1;
	localparam int CAUSE_SDP6 = 2;
	localparam int CAUSE_SDP7 = 3;

	// ICR bit of each cause, by cell index
	localparam int CAUSE_ICR_BIT [NUM_CAUSES] = '{2, 12, 13, 14};

	typedef logic [NUM_CAUSES-1:0] cause_vec_t;

	// Software set/clear towards one cell
	typedef struct packed {
		logic set;
		logic clr;
	} cause_ctl_t;

	localparam int ITR_W = 16;  // Interval field of ITR

endpackage

`default_nettype wire

//--- verilog/e1000_reg_pkg.sv
`default_nettype none

package e1000_reg_pkg;

	localparam int APB_ADDR_W = 16;
	localparam int REG_W = 32;

	// Register map, byte offsets
	localparam logic [APB_ADDR_W-1:0] CTRL_OFS   = 16'h0000;
	localparam logic [APB_ADDR_W-1:0] STATUS_OFS = 16'h0008;
	localparam logic [APB_ADDR_W-1:0] ICR_OFS    = 16'h00C0;
	localparam logic [APB_ADDR_W-1:0] ITR_OFS    = 16'h00C4;
	localparam logic [APB_ADDR_W-1:0] ICS_OFS    = 16'h00C8;
	localparam logic [APB_ADDR_W-1:0] IMS_OFS    = 16'h00D0;
	localparam logic [APB_ADDR_W-1:0] IMC_OFS    = 16'h00D8;

	localparam int CTRL_RST_BIT = 26;     // Device reset, self clearing
	localparam int CTRL_PHY_RST_BIT = 31;

	localparam int STATUS_FD_BIT = 0;
	localparam int STATUS_LU_BIT = 1;
	localparam int STATUS_SPEED_LSB = 6;  // 00 10M, 01 100M, 1x 1000M

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [REG_W-1:0]      pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [REG_W-1:0] prdata;
		logic             pready;
		logic             pslverr;
	} apb_rsp_t;

	// Live PHY pins
	typedef struct packed {
		logic       duplex;
		logic       link_up;
		logic [1:0] speed;
	} phy_status_t;

endpackage

`default_nettype wire
